/* compile.f */
rtl/opll_reg_pkg.sv
rtl/bus_sync.sv
rtl/slot_timer.sv
rtl/patch_reg.sv
rtl/chan_reg.sv
rtl/inst_rom.sv
rtl/param_select.sv
rtl/opll_reg_top.sv
testbench/opll_reg_asserts.sv
testbench/tb_opll_reg.sv

/* Bender.yml */
package:
  name: opll_reg

sources:
  - rtl/opll_reg_pkg.sv
  - rtl/bus_sync.sv
  - rtl/slot_timer.sv
  - rtl/patch_reg.sv
  - rtl/chan_reg.sv
  - rtl/inst_rom.sv
  - rtl/param_select.sv
  - rtl/opll_reg_top.sv
  - target: simulation
    files:
      - testbench/opll_reg_asserts.sv
      - testbench/tb_opll_reg.sv

/* testbench/tb_opll_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_opll_reg;
    import opll_reg_pkg::*;

    typedef enum logic [1:0] {
        E_WRITE,
        E_CHAN,
        E_PARAM
    } entry_kind_e;

    // one table row: a register write or a check of one slot
    typedef struct packed {
        entry_kind_e kind;
        logic [7:0]  addr;
        logic [7:0]  data;
        logic [3:0]  ch;
        op_half_e    half;
        chan_t       exp_chan;
        slot_param_t exp_param;
    } entry_t;

    logic        i_EMUCLK;
    logic        i_IC_n;
    logic        i_CS_n;
    logic        i_WR_n;
    logic        i_A0;
    logic [7:0]  i_D;
    slot_t       o_SLOT;
    chan_t       o_CHAN;
    slot_param_t o_PARAM;

    entry_t      tab[$];
    chan_t       chan_m [NUM_CH];   // expected channel registers
    slot_param_t cust_mod;
    slot_param_t cust_car;          // tl filled from vol per check
    slot_param_t rom_mod [16];
    slot_param_t rom_car [16];
    logic [31:0] rng;
    logic        built;
    int          n_checks;
    int          n_errors;
    int          n_timeouts;
    int          n_asserts;

    opll_reg_top dut0 (
        .i_EMUCLK (i_EMUCLK),
        .i_IC_n   (i_IC_n),
        .i_CS_n   (i_CS_n),
        .i_WR_n   (i_WR_n),
        .i_A0     (i_A0),
        .i_D      (i_D),
        .o_SLOT   (o_SLOT),
        .o_CHAN   (o_CHAN),
        .o_PARAM  (o_PARAM)
    );

    always #20 i_EMUCLK = ~i_EMUCLK;

    //////////////////////////////
    // helpers

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] rand_byte();
        rng = xorshift(rng);
        return rng[7:0];
    endfunction

    function automatic op_param_t mk_op(input logic [3:0] flags, input logic [3:0] mul,
                                        input logic [1:0] ksl, input logic [3:0] ar,
                                        input logic [3:0] dr, input logic [3:0] sl,
                                        input logic [3:0] rr);
        op_param_t op;
        {op.am, op.pm, op.etyp, op.ksr} = flags;    // am pm etyp ksr
        op.mul = mul;
        op.ksl = ksl;
        op.ar  = ar;
        op.dr  = dr;
        op.sl  = sl;
        op.rr  = rr;
        return op;
    endfunction

    function automatic slot_param_t mk_param(input op_param_t op, input logic [5:0] tl,
                                             input logic dc, input logic dm,
                                             input logic [2:0] fb);
        slot_param_t p;
        p.op = op;
        p.tl = tl;
        p.dc = dc;
        p.dm = dm;
        p.fb = fb;
        return p;
    endfunction

    // channel bank rules of the register map
    function automatic void model_write(input logic [7:0] addr, input logic [7:0] data);
        int ch;
        ch = int'(addr[3:0]);
        if (ch < NUM_CH) begin
            case (addr[7:4])
                4'h1: chan_m[ch].fnum[7:0] = data;
                4'h2: begin
                    chan_m[ch].fnum[8] = data[0];
                    chan_m[ch].block   = data[3:1];
                    chan_m[ch].kon     = data[4];
                    chan_m[ch].susen   = data[5];
                end
                4'h3: begin
                    chan_m[ch].vol  = data[3:0];
                    chan_m[ch].inst = data[7:4];
                end
                default: ;
            endcase
        end
    endfunction

    function automatic slot_param_t expect_param(input int ch, input op_half_e half);
        slot_param_t p;
        logic [3:0]  inst;
        inst = chan_m[ch].inst;
        if (inst == CUSTOM_INST) begin
            p = (half == OP_MOD) ? cust_mod : cust_car;
        end else begin
            p = (half == OP_MOD) ? rom_mod[inst] : rom_car[inst];
        end
        if (half == OP_CAR) begin
            p.tl = 6'(chan_m[ch].vol * 4);          // carrier level from volume
        end
        return p;
    endfunction

    task automatic add_write(input logic [7:0] addr, input logic [7:0] data);
        entry_t e;
        e = '0;
        e.kind = E_WRITE;
        e.addr = addr;
        e.data = data;
        tab.push_back(e);
        model_write(addr, data);
    endtask

    task automatic add_check(input entry_kind_e kind, input int ch, input op_half_e half);
        entry_t e;
        e = '0;
        e.kind      = kind;
        e.ch        = 4'(ch);
        e.half      = half;
        e.exp_chan  = chan_m[ch];
        e.exp_param = expect_param(ch, half);
        tab.push_back(e);
    endtask

    //////////////////////////////
    // stimulus table

    task automatic build_table();
        int c1;
        int c2;
        int c3;
        foreach (chan_m[i]) chan_m[i] = '0;
        foreach (rom_mod[i]) begin
            rom_mod[i] = '0;
            rom_car[i] = '0;
        end
        cust_mod = '0;
        cust_car = '0;
        // rom rows 1 and 3 split by operator
        rom_mod[1] = mk_param(mk_op(4'b0111, 4'h1, 2'd0, 4'hD, 4'h0, 4'h0, 4'h0),
                              6'd30, 1'b1, 1'b0, 3'd7);
        rom_car[1] = mk_param(mk_op(4'b0110, 4'h1, 2'd0, 4'h7, 4'h8, 4'h1, 4'h7),
                              6'd0, 1'b1, 1'b0, 3'd7);
        rom_mod[3] = mk_param(mk_op(4'b0001, 4'h3, 2'd2, 4'hF, 4'h2, 4'h1, 4'h1),
                              6'd25, 1'b0, 1'b0, 3'd0);
        rom_car[3] = mk_param(mk_op(4'b0000, 4'h1, 2'd0, 4'hC, 4'h4, 4'h2, 4'h3),
                              6'd0, 1'b0, 1'b0, 3'd0);

        for (int ch = 0; ch < NUM_CH; ch++) begin  // everything zero after reset
            add_check(E_CHAN, ch, OP_MOD);
            add_check(E_PARAM, ch, OP_MOD);
            add_check(E_PARAM, ch, OP_CAR);
        end

        c1 = int'(rand_byte()) % NUM_CH;
        c2 = (c1 + 1 + int'(rand_byte()) % 4) % NUM_CH;
        c3 = (c1 + 5 + int'(rand_byte()) % 4) % NUM_CH;

        add_write(8'(8'h10 + c1), rand_byte());
        add_write(8'(8'h20 + c1), rand_byte());
        add_write(8'(8'h30 + c1), rand_byte() & 8'h0F);
        add_write(8'(8'h10 + c2), rand_byte());
        add_write(8'(8'h20 + c2), rand_byte());
        add_check(E_CHAN, c1, OP_MOD);
        add_check(E_CHAN, c2, OP_MOD);
        add_check(E_CHAN, c3, OP_MOD);
        add_write(8'h19, 8'hFF);                  // no channel 9
        add_write(8'h40, 8'hFF);                  // no bank 4
        add_check(E_CHAN, c1, OP_MOD);
        add_check(E_CHAN, c2, OP_MOD);
        add_check(E_CHAN, 8, OP_MOD);

        // custom patch, expected fields follow the register layout
        add_write(8'h00, 8'hA5);
        add_write(8'h01, 8'h5C);
        add_write(8'h02, 8'h9B);
        add_write(8'h03, 8'hD6);
        add_write(8'h04, 8'h3E);
        add_write(8'h05, 8'hC7);
        add_write(8'h06, 8'h81);
        add_write(8'h07, 8'h2F);
        cust_mod = mk_param(mk_op(4'b1010, 4'h5, 2'd2, 4'h3, 4'hE, 4'h8, 4'h1),
                            6'h1B, 1'b1, 1'b0, 3'd6);
        cust_car = mk_param(mk_op(4'b0101, 4'hC, 2'd3, 4'hC, 4'h7, 4'h2, 4'hF),
                            6'h00, 1'b1, 1'b0, 3'd6);
        add_write(8'(8'h30 + c1), rand_byte() & 8'h0F);
        add_check(E_PARAM, c1, OP_MOD);
        add_check(E_PARAM, c1, OP_CAR);
        add_check(E_CHAN, c1, OP_MOD);

        add_write(8'(8'h30 + c2), 8'h10 | (rand_byte() & 8'h0F));
        add_write(8'(8'h30 + c3), 8'h30 | (rand_byte() & 8'h0F));
        add_check(E_PARAM, c2, OP_MOD);
        add_check(E_PARAM, c2, OP_CAR);
        add_check(E_PARAM, c3, OP_MOD);
        add_check(E_PARAM, c3, OP_CAR);
        add_check(E_PARAM, c1, OP_MOD);
        add_check(E_PARAM, c1, OP_CAR);
        add_check(E_CHAN, c2, OP_MOD);
        add_check(E_CHAN, c3, OP_MOD);

        // data after an invalid address
        add_write(8'h08, 8'h00);
        add_write(8'h0F, 8'hFF);
        add_write(8'h39, 8'h00);
        add_write(8'h2A, 8'hFF);
        add_check(E_PARAM, c1, OP_MOD);
        add_check(E_PARAM, c1, OP_CAR);
        add_check(E_PARAM, c3, OP_CAR);
        add_check(E_CHAN, c1, OP_MOD);
        add_check(E_CHAN, c2, OP_MOD);
        add_check(E_CHAN, c3, OP_MOD);
    endtask

    //////////////////////////////
    // bus and checks

    task automatic bus_write(input logic a0, input logic [7:0] d);
        @(posedge i_EMUCLK);
        #5;
        i_CS_n = 1'b0;
        i_WR_n = 1'b0;
        i_A0   = a0;
        i_D    = d;
        repeat (3) @(posedge i_EMUCLK);
        #5;
        i_CS_n = 1'b1;
        i_WR_n = 1'b1;
        repeat (3) @(posedge i_EMUCLK);
    endtask

    task automatic wait_slot(input logic [3:0] ch, input op_half_e half, output logic found);
        found = 1'b0;
        repeat (2) @(posedge i_EMUCLK);             // let the rom row settle
        for (int n = 0; n < 2 * NUM_SLOT && !found; n++) begin
            @(negedge i_EMUCLK);
            if (o_SLOT.ch == ch && o_SLOT.half == half) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            n_timeouts++;
            $display("ERROR: slot of channel %0d half %0d never appeared on o_SLOT at %0t",
                     ch, half, $time);
        end
    endtask

    task automatic check_chan(input chan_t got, input chan_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED @%0t: %s o_CHAN %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_param(input slot_param_t got, input slot_param_t exp,
                               input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED @%0t: %s o_PARAM %h expected %h", $time, what, got, exp);
        end
    endtask

    //////////////////////////////
    // main flow

    initial begin
        logic found;
        i_EMUCLK   = 1'b0;
        i_IC_n     = 1'b0;
        i_CS_n     = 1'b1;
        i_WR_n     = 1'b1;
        i_A0       = 1'b0;
        i_D        = 8'h00;
        rng        = 32'd51612;
        built      = 1'b0;
        n_checks   = 0;
        n_errors   = 0;
        n_timeouts = 0;
        build_table();
        built = 1'b1;
        repeat (8) @(posedge i_EMUCLK);
        #5;
        i_IC_n = 1'b1;

        for (int i = 0; i < tab.size(); i++) begin
            case (tab[i].kind)
                E_WRITE: begin
                    bus_write(1'b0, tab[i].addr);
                    bus_write(1'b1, tab[i].data);
                end
                E_CHAN: begin
                    wait_slot(tab[i].ch, OP_MOD, found);
                    if (found) begin
                        check_chan(o_CHAN, tab[i].exp_chan,
                                   $sformatf("entry %0d ch %0d", i, tab[i].ch));
                    end
                end
                default: begin
                    wait_slot(tab[i].ch, tab[i].half, found);
                    if (found) begin
                        check_param(o_PARAM, tab[i].exp_param,
                                    $sformatf("entry %0d ch %0d half %0d", i, tab[i].ch,
                                              tab[i].half));
                    end
                end
            endcase
        end

        n_asserts = dut0.u_slot_timer.u_slot_chk.n_fail + dut0.u_bus_sync.u_wr_chk.n_fail;
        $display("checks %0d, value errors %0d, slot timeouts %0d, assertion failures %0d",
                 n_checks, n_errors, n_timeouts, n_asserts);
        if (n_errors == 0 && n_timeouts == 0 && n_asserts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // run limit scales with the table
    initial begin : watchdog
        wait (built);
        repeat (tab.size() * 60 + 200) @(posedge i_EMUCLK);
        $display("ERROR: watchdog expired, the table did not finish in %0d cycles",
                 tab.size() * 60 + 200);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/opll_reg_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module opll_reg_asserts #(
    parameter bit CHK_SLOT = 1'b1   // slot order, otherwise write pulses
) (
    input wire                         i_EMUCLK,
    input wire                         i_IC_n,
    input wire opll_reg_pkg::slot_t    i_slot,
    input wire opll_reg_pkg::bus_wr_t  i_wr
);

    int unsigned n_fail = 0;
    logic [4:0]  slot_num;

    assign slot_num = {i_slot.ch, i_slot.half};    // ch * 2 + half

    if (CHK_SLOT) begin : g_slot
        a_slot_step: assert property (@(posedge i_EMUCLK) disable iff (!i_IC_n)
            slot_num != 5'd17 |=> slot_num == $past(slot_num) + 5'd1)
        else begin
            $error("slot did not advance by one");
            n_fail++;
        end

        a_slot_wrap: assert property (@(posedge i_EMUCLK) disable iff (!i_IC_n)
            slot_num == 5'd17 |=> slot_num == 5'd0)
        else begin
            $error("slot did not wrap from 17 to 0");
            n_fail++;
        end
    end else begin : g_wr
        a_no_overlap: assert property (@(posedge i_EMUCLK) disable iff (!i_IC_n)
            !(i_wr.addr_wr && i_wr.data_wr))
        else begin
            $error("address and data pulse high together");
            n_fail++;
        end

        a_addr_pulse: assert property (@(posedge i_EMUCLK) disable iff (!i_IC_n)
            i_wr.addr_wr |=> !i_wr.addr_wr)
        else begin
            $error("address pulse longer than one cycle");
            n_fail++;
        end

        a_data_pulse: assert property (@(posedge i_EMUCLK) disable iff (!i_IC_n)
            i_wr.data_wr |=> !i_wr.data_wr)
        else begin
            $error("data pulse longer than one cycle");
            n_fail++;
        end
    end

endmodule

bind slot_timer opll_reg_asserts #(.CHK_SLOT(1'b1)) u_slot_chk (
    .i_EMUCLK (i_EMUCLK),
    .i_IC_n   (i_IC_n),
    .i_slot   (o_slot),
    .i_wr     ('0)
);

bind bus_sync opll_reg_asserts #(.CHK_SLOT(1'b0)) u_wr_chk (
    .i_EMUCLK (i_EMUCLK),
    .i_IC_n   (i_IC_n),
    .i_slot   ('0),
    .i_wr     (o_wr)
);

`default_nettype wire

/* rtl/opll_reg_top.sv */
`timescale 1ns/1ns
`default_nettype none

module opll_reg_top (
    input  wire                         i_EMUCLK,
    input  wire                         i_IC_n,
    input  wire                         i_CS_n,
    input  wire                         i_WR_n,
    input  wire                         i_A0,
    input  wire  [7:0]                  i_D,
    output opll_reg_pkg::slot_t         o_SLOT,
    output opll_reg_pkg::chan_t         o_CHAN,
    output opll_reg_pkg::slot_param_t   o_PARAM
);
    import opll_reg_pkg::*;

    bus_wr_t wr;
    slot_t   slot;
    slot_t   slot_z1;       // same slot as the chan record
    chan_t   chan;
    patch_t  custom_patch;
    patch_t  rom_patch;

    //////////////////////////////
    // blocks

    bus_sync u_bus_sync (
        .i_EMUCLK (i_EMUCLK),
        .i_IC_n   (i_IC_n),
        .i_CS_n   (i_CS_n),
        .i_WR_n   (i_WR_n),
        .i_A0     (i_A0),
        .i_D      (i_D),
        .o_wr     (wr)
    );

    slot_timer u_slot_timer (
        .i_EMUCLK (i_EMUCLK),
        .i_IC_n   (i_IC_n),
        .o_slot   (slot)
    );

    patch_reg u_patch_reg (
        .i_EMUCLK (i_EMUCLK),
        .i_IC_n   (i_IC_n),
        .i_wr     (wr),
        .o_patch  (custom_patch)
    );

    chan_reg u_chan_reg (
        .i_EMUCLK (i_EMUCLK),
        .i_IC_n   (i_IC_n),
        .i_wr     (wr),
        .i_slot   (slot),
        .o_chan   (chan)
    );

    inst_rom u_inst_rom (
        .i_EMUCLK (i_EMUCLK),
        .i_slot   (slot_z1),
        .i_inst   (chan.inst),
        .o_patch  (rom_patch)
    );

    param_select u_param_select (
        .i_EMUCLK (i_EMUCLK),
        .i_IC_n   (i_IC_n),
        .i_slot   (slot_z1),
        .i_chan   (chan),
        .i_custom (custom_patch),
        .i_rom    (rom_patch),
        .o_param  (o_PARAM)
    );

    //////////////////////////////
    // output alignment
    // params come out two cycles after the slot, chan record one

    always_ff @(posedge i_EMUCLK or negedge i_IC_n) begin
        if (!i_IC_n) begin
            slot_z1 <= '0;
            o_SLOT  <= '0;
            o_CHAN  <= '0;
        end else begin
            slot_z1 <= slot;
            o_SLOT  <= slot_z1;
            o_CHAN  <= chan;
        end
    end

endmodule

`default_nettype wire

/* rtl/param_select.sv */
`timescale 1ns/1ns
`default_nettype none

module param_select (
    input  wire                         i_EMUCLK,
    input  wire                         i_IC_n,
    input  wire opll_reg_pkg::slot_t    i_slot,
    input  wire opll_reg_pkg::chan_t    i_chan,
    input  wire opll_reg_pkg::patch_t   i_custom,
    input  wire opll_reg_pkg::patch_t   i_rom,
    output opll_reg_pkg::slot_param_t   o_param
);
    import opll_reg_pkg::*;

    op_half_e   half_q;     // lines up with the rom row
    logic [3:0] vol_q;
    logic [3:0] inst_q;
    patch_t     src;

    always_ff @(posedge i_EMUCLK or negedge i_IC_n) begin
        if (!i_IC_n) begin
            half_q <= OP_MOD;
            vol_q  <= '0;
            inst_q <= '0;
        end else begin
            half_q <= i_slot.half;
            vol_q  <= i_chan.vol;
            inst_q <= i_chan.inst;
        end
    end

    always_comb begin
        src        = (inst_q == CUSTOM_INST) ? i_custom : i_rom;
        o_param.op = (half_q == OP_CAR) ? src.car : src.mod;
        o_param.tl = (half_q == OP_MOD) ? src.tl : {vol_q, 2'b00};  // carrier level from volume
        o_param.dc = src.dc;
        o_param.dm = src.dm;
        o_param.fb = src.fb;
    end

endmodule

`default_nettype wire

/* rtl/inst_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_rom (
    input  wire                         i_EMUCLK,
    input  wire opll_reg_pkg::slot_t    i_slot,
    input  wire [3:0]                   i_inst,
    output opll_reg_pkg::patch_t        o_patch
);
    import opll_reg_pkg::*;

    logic [62:0] row_d;
    logic [62:0] row_q;

    //////////////////////////////
    // melodic patch table
    // TL_DC DM FB_AM PM ET KSR_MUL_KSL_AR_DR_SL_RR, pairs are mod then car

    always_comb begin
        case (i_inst)
            4'h0: row_d = '0;
            4'h1: row_d = 63'b011110_10111_00111110_00010001_0000_11010111_00001000_00000001_00000111;
            4'h2: row_d = 63'b011010_01101_00010010_00110001_0000_11011111_10000111_00100001_00110011;
            4'h3: row_d = 63'b011001_00000_00000010_00110001_1000_11111100_00100100_00010010_00010011;
            4'h4: row_d = 63'b001110_00111_00011110_00010001_0000_10100110_10000100_01110010_00000111;
            4'h5: row_d = 63'b011110_00110_00001110_00100001_0000_11100111_00000110_00000010_00001000;
            4'h6: row_d = 63'b010110_00101_00001110_00010010_0000_11100111_00000001_00000001_00001000;
            4'h7: row_d = 63'b011101_00111_00011100_00010001_0000_10001000_00100001_00010000_00000111;
            4'h8: row_d = 63'b101101_10100_00001100_00110001_0000_10100111_00100010_00000000_00000111;
            4'h9: row_d = 63'b011011_00110_00111100_00010001_0000_01100110_01000101_00010001_00000111;
            4'hA: row_d = 63'b001011_11000_00110100_00010001_0000_10001111_01010111_01110000_00010111;
            4'hB: row_d = 63'b000011_10001_00000010_00110001_1000_11111110_10100100_00010000_00000100;
            4'hC: row_d = 63'b100100_00111_01010010_01110001_0000_11111111_10001000_00100001_00100010;
            4'hD: row_d = 63'b001100_00101_00111001_00010000_0000_11001111_00100101_00100100_00000010;
            4'hE: row_d = 63'b010101_00011_00000000_00010001_0100_11001001_10010101_00000000_00110010;
            4'hF: row_d = 63'b001001_00011_00111000_00010001_1000_11111110_00010100_01000001_00000011;
        endcase
    end

    // one row serves both operators, so it is fetched on the modulator slot
    always_ff @(posedge i_EMUCLK) begin
        if (i_slot.half == OP_MOD) begin
            row_q <= row_d;
        end
    end

    //////////////////////////////
    // unpack row

    always_comb begin
        o_patch.tl       = row_q[62:57];
        o_patch.dc       = row_q[56];
        o_patch.dm       = row_q[55];
        o_patch.fb       = row_q[54:52];
        o_patch.mod.am   = row_q[51];
        o_patch.car.am   = row_q[50];
        o_patch.mod.pm   = row_q[49];
        o_patch.car.pm   = row_q[48];
        o_patch.mod.etyp = row_q[47];
        o_patch.car.etyp = row_q[46];
        o_patch.mod.ksr  = row_q[45];
        o_patch.car.ksr  = row_q[44];
        o_patch.mod.mul  = row_q[43:40];
        o_patch.car.mul  = row_q[39:36];
        o_patch.mod.ksl  = row_q[35:34];
        o_patch.car.ksl  = row_q[33:32];
        o_patch.mod.ar   = row_q[31:28];
        o_patch.car.ar   = row_q[27:24];
        o_patch.mod.dr   = row_q[23:20];
        o_patch.car.dr   = row_q[19:16];
        o_patch.mod.sl   = row_q[15:12];
        o_patch.car.sl   = row_q[11:8];
        o_patch.mod.rr   = row_q[7:4];
        o_patch.car.rr   = row_q[3:0];
    end

endmodule

`default_nettype wire

/* rtl/chan_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module chan_reg (
    input  wire                         i_EMUCLK,
    input  wire                         i_IC_n,
    input  wire opll_reg_pkg::bus_wr_t  i_wr,
    input  wire opll_reg_pkg::slot_t    i_slot,
    output opll_reg_pkg::chan_t         o_chan
);
    import opll_reg_pkg::*;

    logic [3:0] ch_q;
    logic [3:0] bank_q;
    logic       en_q;
    logic       bank_hit;
    logic [7:0] wd;
    chan_t      chan_mem [NUM_CH];

    assign wd       = i_wr.data;
    assign bank_hit = (wd[7:4] == BANK_FNUM) || (wd[7:4] == BANK_CTRL) ||
                      (wd[7:4] == BANK_VOL);

    //////////////////////////////
    // address latch

    always_ff @(posedge i_EMUCLK or negedge i_IC_n) begin
        if (!i_IC_n) begin
            ch_q   <= '0;
            bank_q <= '0;
            en_q   <= 1'b0;
        end else if (i_wr.addr_wr) begin
            ch_q   <= wd[3:0];
            bank_q <= wd[7:4];
            en_q   <= bank_hit && (wd[3:0] <= 4'(NUM_CH - 1));  // 0x19 and up ignored
        end
    end

    //////////////////////////////
    // nine channel array

    always_ff @(posedge i_EMUCLK or negedge i_IC_n) begin
        if (!i_IC_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                chan_mem[i] <= '0;
            end
        end else if (i_wr.data_wr && en_q) begin
            case (bank_q)
                BANK_FNUM: chan_mem[ch_q].fnum[7:0] <= wd;
                BANK_CTRL: begin
                    chan_mem[ch_q].fnum[8] <= wd[0];
                    chan_mem[ch_q].block   <= wd[3:1];
                    chan_mem[ch_q].kon     <= wd[4];
                    chan_mem[ch_q].susen   <= wd[5];
                end
                BANK_VOL: begin
                    chan_mem[ch_q].vol  <= wd[3:0];
                    chan_mem[ch_q].inst <= wd[7:4];
                end
                default: ;
            endcase
        end
    end

    // record of the current slot's channel, one cycle behind the slot
    always_ff @(posedge i_EMUCLK or negedge i_IC_n) begin
        if (!i_IC_n) begin
            o_chan <= '0;
        end else begin
            o_chan <= chan_mem[i_slot.ch];
        end
    end

endmodule

`default_nettype wire

/* rtl/patch_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module patch_reg (
    input  wire                         i_EMUCLK,
    input  wire                         i_IC_n,
    input  wire opll_reg_pkg::bus_wr_t  i_wr,
    output opll_reg_pkg::patch_t        o_patch
);
    import opll_reg_pkg::*;

    logic [2:0] addr_q;
    logic       addr_ok;    // last address hit 0x00..0x07
    logic [7:0] wd;

    assign wd = i_wr.data;

    //////////////////////////////
    // address latch

    always_ff @(posedge i_EMUCLK or negedge i_IC_n) begin
        if (!i_IC_n) begin
            addr_q  <= '0;
            addr_ok <= 1'b0;
        end else if (i_wr.addr_wr) begin
            addr_ok <= (wd <= PATCH_LAST_ADDR);
            if (wd[7:4] == 4'h0) begin
                addr_q <= wd[2:0];
            end
        end
    end

    //////////////////////////////
    // custom patch registers

    always_ff @(posedge i_EMUCLK or negedge i_IC_n) begin
        if (!i_IC_n) begin
            o_patch <= '0;
        end else if (i_wr.data_wr && addr_ok) begin
            case (addr_q)
                3'd0: {o_patch.mod.am, o_patch.mod.pm, o_patch.mod.etyp,
                       o_patch.mod.ksr, o_patch.mod.mul} <= wd;
                3'd1: {o_patch.car.am, o_patch.car.pm, o_patch.car.etyp,
                       o_patch.car.ksr, o_patch.car.mul} <= wd;
                3'd2: {o_patch.mod.ksl, o_patch.tl} <= wd;
                3'd3: begin
                    o_patch.car.ksl <= wd[7:6];
                    {o_patch.dc, o_patch.dm, o_patch.fb} <= wd[4:0];   // bit 5 unused
                end
                3'd4: {o_patch.mod.ar, o_patch.mod.dr} <= wd;
                3'd5: {o_patch.car.ar, o_patch.car.dr} <= wd;
                3'd6: {o_patch.mod.sl, o_patch.mod.rr} <= wd;
                3'd7: {o_patch.car.sl, o_patch.car.rr} <= wd;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/slot_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module slot_timer (
    input  wire                     i_EMUCLK,
    input  wire                     i_IC_n,
    output opll_reg_pkg::slot_t     o_slot
);
    import opll_reg_pkg::*;

    logic [4:0] slot_cnt;

    always_ff @(posedge i_EMUCLK or negedge i_IC_n) begin
        if (!i_IC_n) begin
            slot_cnt <= '0;
        end else if (slot_cnt == 5'(NUM_SLOT - 1)) begin
            slot_cnt <= '0;                 // frame wrap
        end else begin
            slot_cnt <= slot_cnt + 5'd1;
        end
    end

    // even slot is the modulator, odd the carrier of the same channel
    always_comb begin
        o_slot.ch   = slot_cnt[4:1];
        o_slot.half = slot_cnt[0] ? OP_CAR : OP_MOD;
    end

endmodule

`default_nettype wire

/* rtl/bus_sync.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_sync (
    input  wire                     i_EMUCLK,
    input  wire                     i_IC_n,
    input  wire                     i_CS_n,
    input  wire                     i_WR_n,
    input  wire                     i_A0,
    input  wire  [7:0]              i_D,
    output opll_reg_pkg::bus_wr_t   o_wr
);

    logic [1:0] cs_n_s;     // two flop chains
    logic [1:0] wr_n_s;
    logic [1:0] a0_s;
    logic [7:0] d_s0;
    logic [7:0] d_s1;
    logic       wr_prev;
    logic       wr_now;
    logic       wr_rise;

    always_ff @(posedge i_EMUCLK or negedge i_IC_n) begin
        if (!i_IC_n) begin
            cs_n_s <= 2'b11;
            wr_n_s <= 2'b11;
            a0_s   <= 2'b00;
        end else begin
            cs_n_s <= {cs_n_s[0], i_CS_n};
            wr_n_s <= {wr_n_s[0], i_WR_n};
            a0_s   <= {a0_s[0], i_A0};
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        d_s0 <= i_D;
        d_s1 <= d_s0;
    end

    assign wr_now  = ~(cs_n_s[1] | wr_n_s[1]);
    assign wr_rise = wr_now & ~wr_prev;     // once per strobe-low period

    // pulse and data leave together, data held until the next write
    always_ff @(posedge i_EMUCLK or negedge i_IC_n) begin
        if (!i_IC_n) begin
            wr_prev <= 1'b0;
            o_wr    <= '0;
        end else begin
            wr_prev      <= wr_now;
            o_wr.addr_wr <= wr_rise & ~a0_s[1];
            o_wr.data_wr <= wr_rise & a0_s[1];
            if (wr_rise) begin
                o_wr.data <= d_s1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/opll_reg_pkg.sv */
`default_nettype none

package opll_reg_pkg;

    //////////////////////////////
    // register map

    localparam int NUM_CH   = 9;
    localparam int NUM_SLOT = 18;                    // modulator + carrier per channel

    localparam logic [7:0] PATCH_LAST_ADDR = 8'h07;  // custom patch lives in 0x00..0x07
    localparam logic [3:0] BANK_FNUM       = 4'h1;   // fnum low byte
    localparam logic [3:0] BANK_CTRL       = 4'h2;   // fnum msb, block, key-on, sustain
    localparam logic [3:0] BANK_VOL        = 4'h3;   // volume and instrument
    localparam logic [3:0] CUSTOM_INST     = 4'h0;

    //////////////////////////////
    // types

    typedef enum logic {
        OP_MOD = 1'b0,
        OP_CAR = 1'b1
    } op_half_e;

    // one synchronized cpu write
    typedef struct packed {
        logic       addr_wr;
        logic       data_wr;
        logic [7:0] data;
    } bus_wr_t;

    typedef struct packed {
        logic [3:0] ch;
        op_half_e   half;
    } slot_t;

    // per operator fields, same order as the register bit layout
    typedef struct packed {
        logic       am;
        logic       pm;
        logic       etyp;
        logic       ksr;
        logic [3:0] mul;
        logic [1:0] ksl;
        logic [3:0] ar;
        logic [3:0] dr;
        logic [3:0] sl;
        logic [3:0] rr;
    } op_param_t;

    typedef struct packed {
        op_param_t  mod;
        op_param_t  car;
        logic [5:0] tl;   // modulator only
        logic       dc;
        logic       dm;
        logic [2:0] fb;
    } patch_t;

    typedef struct packed {
        logic [8:0] fnum;
        logic [2:0] block;
        logic       kon;
        logic       susen;
        logic [3:0] vol;
        logic [3:0] inst;
    } chan_t;

    typedef struct packed {
        op_param_t  op;
        logic [5:0] tl;
        logic       dc;
        logic       dm;
        logic [2:0] fb;
    } slot_param_t;

endpackage

`default_nettype wire
